// ==== verilog.f ====
+incdir+tb
hdl/corePkg.sv
hdl/instrDecode.sv
hdl/intExecute.sv
hdl/resultStage.sv
hdl/intCore.sv
tb/tbIntCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbIntCore
LINTTOP   ?= intCore
FLIST     ?= verilog.f
VFLAGS    ?= --timing
LINTFLAGS ?= -Wall
OBJDIR    ?= obj_dir
PASSTEXT  ?= TEST PASS

.PHONY: all lint sim clean

all: sim

# lint the core on its own, with the testbench parsed but not elaborated
lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) --top-module $(LINTTOP) -f $(FLIST)

# build, run, and decide by the pass line in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// ==== tb/refModel.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

logic [31:0] lfsr = 32'hf6a0;
logic [31:0] shadowRegs [32] = '{default: '0};  // x0 entry is never written
logic [4:0]  recentRd [3] = '{default: '0};     // newest legal destination first

////////////////////
// random source

// taps x^32 + x^22 + x^2 + x + 1 with one step per bit taken
function automatic logic [31:0] randBits(int n);
  logic [31:0] bits;
  logic        fb;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    bits = {bits[30:0], fb};
  end
  return bits;
endfunction

////////////////////
// instruction generators

// often reuse a destination from 1, 2 or 3 instructions back
function automatic logic [4:0] pickSrc();
  logic [1:0] sel;
  sel = 2'(randBits(2));
  if (sel != 2'd3 && 1'(randBits(1)) == 1'b1)
    return recentRd[sel];
  return 5'(randBits(5));
endfunction

function automatic logic [4:0] pickRd();
  if (4'(randBits(4)) == 4'd0)
    return 5'd0;  // extra x0 writes
  return 5'(randBits(5));
endfunction

function automatic logic [31:0] genLegal();
  logic [2:0] f3;
  logic [4:0] rd, rs1, rs2;
  logic       alt;
  f3  = 3'(randBits(3));
  rd  = pickRd();
  rs1 = pickSrc();
  rs2 = pickSrc();
  alt = 1'(randBits(1));
  case (3'(randBits(3)))
    3'd0, 3'd1, 3'd2: begin  // register form
      alt = alt && (f3 == 3'd0 || f3 == 3'd5);
      return {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
    end
    3'd3, 3'd4, 3'd5: begin  // immediate form where rs2 doubles as shamt
      if (f3 == 3'd1)
        return {7'h00, rs2, rs1, f3, rd, 7'b0010011};
      if (f3 == 3'd5)
        return {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0010011};
      return {12'(randBits(12)), rs1, f3, rd, 7'b0010011};
    end
    3'd6: return {20'(randBits(20)), rd, 7'b0110111};  // lui
    default: return {7'h01, rs2, rs1, 3'd0, rd, 7'b0110011};  // mul
  endcase
endfunction

// words outside the kept set with some close to legal ones
function automatic logic [31:0] genIllegal();
  logic [31:0] word;
  word = randBits(32);
  case (2'(randBits(2)))
    2'd0: begin  // M extension other than mul
      word[6:0]   = 7'b0110011;
      word[31:25] = 7'h01;
      if (word[14:12] == 3'd0)
        word[14:12] = 3'd4;
    end
    2'd1: begin
      word[6:0]   = 7'b0110011;
      word[31:25] = 7'h20;  // only sub and sra take this
      if (word[14:12] == 3'd0 || word[14:12] == 3'd5)
        word[14:12] = 3'd7;
    end
    2'd2: begin  // slli or srai slot with stray upper bits
      word[6:0]   = 7'b0010011;
      word[14:12] = {word[14], 2'b01};
      word[31:25] = word[31:25] | 7'h40;
    end
    default: begin
      if (word[6:0] inside {7'b0110011, 7'b0010011, 7'b0110111})
        word[6] = 1'b1;  // moves into an unused major opcode
    end
  endcase
  return word;
endfunction

////////////////////
// architectural model

function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << sh;
    3'd2: return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};  // signed via bias
    3'd3: return {31'b0, a < b};
    3'd4: return a ^ b;
    3'd5: return (alt && a[31]) ? (a >> sh) | ~(32'hffff_ffff >> sh) : a >> sh;
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// one word in program order with the shadow registers updated right away
task automatic runModel(input logic [31:0] word, output bit legal,
                        output logic [4:0] rd, output logic [31:0] value);
  logic [31:0] a, b;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic        isImm;
  f7    = word[31:25];
  f3    = word[14:12];
  rd    = word[11:7];
  isImm = (word[6:0] == 7'b0010011);
  a     = shadowRegs[word[19:15]];
  b     = isImm ? {{20{word[31]}}, word[31:20]} : shadowRegs[word[24:20]];
  legal = 1'b1;
  value = '0;
  if (word[6:0] == 7'b0110111) begin
    value = {word[31:12], 12'h000};
  end else if (word[6:0] == 7'b0110011 && f7 == 7'h01) begin
    legal = mulOn && f3 == 3'd0;
    value = a * b;
  end else if (word[6:0] == 7'b0110011 || isImm) begin
    if (!isImm || f3 == 3'd1 || f3 == 3'd5)  // funct7 only matters here
      legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd5 || (f3 == 3'd0 && !isImm)));
    value = aluModel(f3, f7 == 7'h20 && (f3 == 3'd5 || !isImm), a, b);
  end else begin
    legal = 1'b0;
  end
  if (legal && rd != 5'd0)
    shadowRegs[rd] = value;
endtask

`endif

// ==== tb/tbIntCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbIntCore;

  localparam int numSlots    = 2000;  // issue slots including idle ones
  localparam int resetCycles = 8;
  localparam int maxCycles   = numSlots + resetCycles + 50;
  localparam int driveDelay  = 2;     // ns after the rising edge
  localparam bit mulOn       = 1'b1;

  typedef struct packed {
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] due;  // cycle count when the pulse must be seen
  } expRecord;

  logic        clk, rst;
  logic        instrValid;
  logic [31:0] instr;
  logic        retireValid, illegalInstr;
  logic [4:0]  retireRd;
  logic [31:0] retireData;

  int       cycle = 0;
  int       errors = 0;
  int       retired = 0;
  int       illegals = 0;
  bit       timedOut = 1'b0;
  expRecord expQ [$];
  expRecord head;

  `include "refModel.svh"

  intCore #(.mulSupported(mulOn)) intCore_inst (
    .clk, .rst, .instrValid, .instr,
    .retireValid, .retireRd, .retireData, .illegalInstr);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////
  // stimulus

  // drive one word and queue the record the model predicts
  task automatic issueWord(input logic [31:0] word);
    expRecord    rec;
    bit          legal;
    logic [4:0]  rd;
    logic [31:0] value;
    instrValid = 1'b1;
    instr      = word;
    runModel(word, legal, rd, value);
    rec.illegal = !legal;
    rec.rd      = rd;
    rec.data    = value;
    rec.due     = cycle + 3;  // sampled at the next edge and seen two edges later
    expQ.push_back(rec);
    if (legal) begin
      recentRd[2] = recentRd[1];
      recentRd[1] = recentRd[0];
      recentRd[0] = rd;
    end
  endtask

  initial begin
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    repeat (resetCycles) @(posedge clk);
    #driveDelay rst = 1'b0;
    repeat (4) @(posedge clk);  // quiet window after reset
    for (int slot = 0; slot < numSlots; slot++) begin
      @(posedge clk);
      #driveDelay;
      if (3'(randBits(3)) == 3'd0) begin
        instrValid = 1'b0;
        instr      = randBits(32);  // junk on an idle bus
      end else if (4'(randBits(4)) == 4'd0) begin
        issueWord(genIllegal());
      end else begin
        issueWord(genLegal());
      end
    end
    @(posedge clk);
    #driveDelay instrValid = 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);  // nothing may follow the last pulse
    endRun();
  end

  ////////////////////
  // checking

  task automatic checkPulse(input expRecord e);
    if (cycle != e.due) begin
      errors++;
      $display("pulse seen at cycle %0d but expected at cycle %0d", cycle, e.due);
    end
    if (retireValid != !e.illegal) begin
      errors++;
      $display("Error: retireValid got %h expected %h", retireValid, !e.illegal);
    end
    if (illegalInstr != e.illegal) begin
      errors++;
      $display("Error: illegalInstr got %h expected %h", illegalInstr, e.illegal);
    end
    if (!e.illegal && retireRd != e.rd) begin
      errors++;
      $display("Error: retireRd got %h expected %h", retireRd, e.rd);
    end
    if (!e.illegal && retireData != e.data) begin
      errors++;
      $display("Error: retireData got %h expected %h", retireData, e.data);
    end
    if (e.illegal)
      illegals++;
    else
      retired++;
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst && (retireValid || illegalInstr)) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("output pulse at cycle %0d with no instruction outstanding", cycle);
      end else begin
        head = expQ.pop_front();
        checkPulse(head);
      end
    end
  end

  task automatic endRun();
    $display("errors %0d, retired %0d, illegal %0d, outstanding %0d",
             errors, retired, illegals, expQ.size());
    if (errors == 0 && !timedOut && expQ.size() == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  endtask

  initial begin
    wait (cycle >= maxCycles);
    timedOut = 1'b1;
    $display("run did not complete within %0d cycles", maxCycles);
    endRun();
  end

endmodule

`default_nettype wire

// ==== hdl/intCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module intCore #(
  parameter bit mulSupported = 1'b1
) (
  input  logic              clk, rst,
  // instruction in, one per cycle at most
  input  logic              instrValid,
  input  corePkg::instrWord instr,
  // retire report
  output logic              retireValid,
  output corePkg::regAddr   retireRd,
  output corePkg::xlenWord  retireData,
  output logic              illegalInstr
);
  import corePkg::*;

  // register file read ports
  regAddr  rs1Addr, rs2Addr;
  xlenWord rs1Data, rs2Data;

  // decode to execute
  logic    validE, illegalE;
  aluOp    opE;
  regAddr  rdE;
  xlenWord srcAE, srcBE;
  xlenWord aluResultE;  // forwarding path from execute

  // execute to result
  logic    validW, illegalW;
  regAddr  rdW;
  xlenWord resultW;

  ////////////////////
  // pipeline stages

  // decode: field extraction, forwarding, E register
  instrDecode #(.mulSupported(mulSupported)) instrDecode_inst (
    .clk, .rst,
    .instrValid, .instr,
    .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
    .aluResultE, .validW, .rdW, .resultW,
    .validE, .illegalE, .opE, .rdE, .srcAE, .srcBE);

  // execute: ALU and optional multiplier, W register
  intExecute #(.mulSupported(mulSupported)) intExecute_inst (
    .clk, .rst,
    .validE, .illegalE, .opE, .rdE, .srcAE, .srcBE,
    .aluResultE,
    .validW, .illegalW, .rdW, .resultW);

  // result: register file write and retire report
  resultStage resultStage_inst (
    .clk, .rst,
    .validW, .illegalW, .rdW, .resultW,
    .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
    .retireValid, .illegalInstr, .retireRd, .retireData);

endmodule

`default_nettype wire

// ==== hdl/resultStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultStage (
  input  logic             clk, rst,
  // from execute
  input  logic             validW, illegalW,
  input  corePkg::regAddr  rdW,
  input  corePkg::xlenWord resultW,
  // read ports for decode
  input  corePkg::regAddr  rs1Addr, rs2Addr,
  output corePkg::xlenWord rs1Data, rs2Data,
  // retire report
  output logic             retireValid, illegalInstr,
  output corePkg::regAddr  retireRd,
  output corePkg::xlenWord retireData
);
  import corePkg::*;

  xlenWord regs [31:1];  // x0 has no storage

  ////////////////////
  // register file

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (validW && rdW != '0) begin
      regs[rdW] <= resultW;
    end
  end

  // x0 reads as zero
  assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
  assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

  ////////////////////
  // retire outputs

  always_ff @(posedge clk) begin
    if (rst) begin
      retireValid  <= 1'b0;
      illegalInstr <= 1'b0;
    end else begin
      retireValid  <= validW;
      illegalInstr <= illegalW;
    end
  end

  // reported even for rd == 0, the write above is what gets suppressed
  always_ff @(posedge clk) begin
    retireRd   <= rdW;
    retireData <= resultW;
  end

endmodule

`default_nettype wire

// ==== hdl/intExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module intExecute #(
  parameter bit mulSupported = 1'b1
) (
  input  logic             clk, rst,
  // from decode
  input  logic             validE, illegalE,
  input  corePkg::aluOp    opE,
  input  corePkg::regAddr  rdE,
  input  corePkg::xlenWord srcAE, srcBE,
  // combinational result, back to decode
  output corePkg::xlenWord aluResultE,
  // result stage register
  output logic             validW, illegalW,
  output corePkg::regAddr  rdW,
  output corePkg::xlenWord resultW
);
  import corePkg::*;

  logic [4:0] shamt;
  xlenWord    mulResult;

  assign shamt = srcBE[4:0];  // upper bits ignored, as for register shifts

  ////////////////////
  // multiplier

  if (mulSupported) begin : genMul
    assign mulResult = srcAE * srcBE;  // low 32 bits of the product
  end else begin : genNoMul
    // decode never issues aluMul in this build
    assign mulResult = '0;
  end

  ////////////////////
  // ALU

  always_comb begin
    case (opE)
      aluAdd:     aluResultE = srcAE + srcBE;
      aluSub:     aluResultE = srcAE - srcBE;
      aluSll:     aluResultE = srcAE << shamt;
      aluSlt:     aluResultE = {31'b0, $signed(srcAE) < $signed(srcBE)};
      aluSltu:    aluResultE = {31'b0, srcAE < srcBE};
      aluXor:     aluResultE = srcAE ^ srcBE;
      aluSrl:     aluResultE = srcAE >> shamt;
      aluSra:     aluResultE = $unsigned($signed(srcAE) >>> shamt);
      aluOr:      aluResultE = srcAE | srcBE;
      aluAnd:     aluResultE = srcAE & srcBE;
      aluLuiPass: aluResultE = srcBE;  // U immediate already shifted
      aluMul:     aluResultE = mulResult;
      default:    aluResultE = '0;
    endcase
  end

  ////////////////////
  // execute to result register

  always_ff @(posedge clk) begin
    if (rst) begin
      validW   <= 1'b0;
      illegalW <= 1'b0;
    end else begin
      validW   <= validE;
      illegalW <= illegalE;
    end
  end

  // data side, only meaningful while validW is set
  always_ff @(posedge clk) begin
    rdW     <= rdE;
    resultW <= aluResultE;
  end

endmodule

`default_nettype wire

// ==== hdl/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode #(
  parameter bit mulSupported = 1'b1
) (
  input  logic              clk, rst,
  // incoming instruction
  input  logic              instrValid,
  input  corePkg::instrWord instr,
  // register file read ports
  output corePkg::regAddr   rs1Addr, rs2Addr,
  input  corePkg::xlenWord  rs1Data, rs2Data,
  // forwarding sources
  input  corePkg::xlenWord  aluResultE,
  input  logic              validW,
  input  corePkg::regAddr   rdW,
  input  corePkg::xlenWord  resultW,
  // execute stage register
  output logic              validE, illegalE,
  output corePkg::aluOp     opE,
  output corePkg::regAddr   rdE,
  output corePkg::xlenWord  srcAE, srcBE
);
  import corePkg::*;

  logic [6:0] opcode, funct7;
  logic [2:0] funct3;
  regAddr     rdD;
  xlenWord    immI, immU, immD;
  aluOp       opD;
  logic       legalD;
  logic       useImmD;
  xlenWord    srcAD, srcBD;

  ////////////////////
  // field extraction

  assign opcode  = instr[6:0];
  assign rdD     = instr[11:7];
  assign funct3  = instr[14:12];
  assign rs1Addr = instr[19:15];
  assign rs2Addr = instr[24:20];
  assign funct7  = instr[31:25];

  assign immI = {{20{instr[31]}}, instr[31:20]};  // shamt lives in the low 5 bits
  assign immU = {instr[31:12], 12'b0};

  ////////////////////
  // operation decode

  always_comb begin
    opD     = aluAdd;
    legalD  = 1'b0;
    useImmD = 1'b0;
    immD    = immI;
    case (opcode)
      opOp: begin
        if (funct7 == f7Base) begin
          legalD = 1'b1;  // every funct3 is defined here
          case (funct3)
            3'b000: opD = aluAdd;
            3'b001: opD = aluSll;
            3'b010: opD = aluSlt;
            3'b011: opD = aluSltu;
            3'b100: opD = aluXor;
            3'b101: opD = aluSrl;
            3'b110: opD = aluOr;
            default: opD = aluAnd;
          endcase
        end else if (funct7 == f7Alt) begin
          if (funct3 == 3'b000) begin
            opD    = aluSub;
            legalD = 1'b1;
          end else if (funct3 == 3'b101) begin
            opD    = aluSra;
            legalD = 1'b1;
          end
        end else if (funct7 == f7MulDiv && mulSupported && funct3 == 3'b000) begin
          opD    = aluMul;  // div/rem and mulh* stay illegal
          legalD = 1'b1;
        end
      end
      opOpImm: begin
        useImmD = 1'b1;
        legalD  = 1'b1;
        case (funct3)
          3'b000: opD = aluAdd;
          3'b010: opD = aluSlt;
          3'b011: opD = aluSltu;
          3'b100: opD = aluXor;
          3'b110: opD = aluOr;
          3'b111: opD = aluAnd;
          3'b001: begin
            opD    = aluSll;
            legalD = (funct7 == f7Base);
          end
          default: begin  // srli / srai
            if (funct7 == f7Base) begin
              opD = aluSrl;
            end else if (funct7 == f7Alt) begin
              opD = aluSra;
            end else begin
              legalD = 1'b0;
            end
          end
        endcase
      end
      opLui: begin
        opD     = aluLuiPass;
        useImmD = 1'b1;
        immD    = immU;
        legalD  = 1'b1;
      end
      default: ;  // anything else is illegal
    endcase
  end

  ////////////////////
  // operand forwarding

  // newest producer wins: execute, then result, then register file
  function automatic xlenWord fwdOperand(regAddr rs, xlenWord rfData);
    if (rs == '0)
      return '0;
    else if (validE && rdE == rs)
      return aluResultE;
    else if (validW && rdW == rs)
      return resultW;
    else
      return rfData;
  endfunction

  assign srcAD = fwdOperand(rs1Addr, rs1Data);
  assign srcBD = useImmD ? immD : fwdOperand(rs2Addr, rs2Data);

  ////////////////////
  // decode to execute register

  always_ff @(posedge clk) begin
    if (rst) begin
      validE   <= 1'b0;
      illegalE <= 1'b0;
    end else begin
      validE   <= instrValid & legalD;
      illegalE <= instrValid & ~legalD;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin  // payload holds across idle cycles
      opE   <= opD;
      rdE   <= rdD;
      srcAE <= srcAD;
      srcBE <= srcBD;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/corePkg.sv ====
`default_nettype none

package corePkg;

  ////////////////////
  // datapath widths

  typedef logic [31:0] xlenWord;   // operands, results, immediates
  typedef logic [31:0] instrWord;  // raw instruction encoding
  typedef logic [4:0]  regAddr;    // x0..x31

  ////////////////////
  // execute select codes

  // one code per operation the execute stage can perform
  typedef enum logic [3:0] {
    aluAdd,      // add, addi
    aluSub,
    aluSll,      // sll, slli
    aluSlt,      // signed compare
    aluSltu,     // unsigned compare
    aluXor,
    aluSrl,
    aluSra,      // arithmetic right shift
    aluOr,
    aluAnd,
    aluLuiPass,  // srcB straight through
    aluMul       // low half of product
  } aluOp;

  ////////////////////
  // encoding constants

  // major opcodes, low two bits included
  localparam logic [6:0] opOp    = 7'b0110011;
  localparam logic [6:0] opOpImm = 7'b0010011;
  localparam logic [6:0] opLui   = 7'b0110111;

  // funct7 field values
  localparam logic [6:0] f7Base   = 7'b0000000;
  localparam logic [6:0] f7Alt    = 7'b0100000;  // sub, sra, srai
  localparam logic [6:0] f7MulDiv = 7'b0000001;  // M extension

endpackage

`default_nettype wire
